// File: sources.f
source/mips_exec_pkg.sv
source/main_decoder.sv
source/alu_decoder.sv
source/alu.sv
source/mips_execute.sv
verif/mips_execute_tb.sv

// File: Bender.yml
package:
  name: mips_execute

sources:
  - source/mips_exec_pkg.sv
  - source/main_decoder.sv
  - source/alu_decoder.sv
  - source/alu.sv
  - source/mips_execute.sv
  - target: test
    files:
      - verif/mips_execute_tb.sv

// File: verif/mips_execute_tb.sv
`timescale 1ns/10ps
module mips_execute_tb;

    localparam int          N_RAND    = 120;    // Random R-type instructions
    localparam logic [31:0] RESET_VAL = 32'h0;  // HI/LO after reset

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] res;
        logic        br;
        logic        il;
        logic        chk;  // Compare HI/LO as well
        logic [31:0] hi;
        logic [31:0] lo;
    } row_t;

    // Funct codes the random phase draws from
    localparam logic [5:0] RAND_FUNCT [17] = '{
        6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b, 6'h00, 6'h02,
        6'h03, 6'h04, 6'h06, 6'h07, 6'h18, 6'h19, 6'h1a, 6'h1b
    };

    logic        clk;
    logic        arst_n;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] result;
    logic [31:0] hi;
    logic [31:0] lo;
    logic        branch_taken;
    logic        illegal;
    logic        result_valid;

    row_t        tbl[$];        // Directed table
    string       tbl_name[$];
    row_t        exp_q[$];      // Strobes still waiting for their result
    string       name_q[$];
    logic [31:0] lfsr = 32'h5d98;
    logic        prev_valid = 1'b0;
    row_t        held = '0;     // Last expected outputs, kept while idle
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    mips_execute #(.RESET_HI_LO(RESET_VAL)) UUT (
        .clk(clk), .arst_n(arst_n), .valid(valid), .instr(instr),
        .rs_value(rs_value), .rt_value(rt_value), .result(result), .hi(hi), .lo(lo),
        .branch_taken(branch_taken), .illegal(illegal), .result_valid(result_valid)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] enc_r(logic [5:0] funct, logic [4:0] sh);
        return {6'h00, 15'h0, sh, funct};  // rs/rt/rd fields unused here
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rt, logic [15:0] imm);
        return {op, 5'h0, rt, imm};
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois form
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected outputs of one R-type instruction
    function automatic row_t model_rtype(logic [5:0] funct, logic [4:0] sh,
                                         logic [31:0] a, logic [31:0] b);
        row_t   r;
        longint p;
        r       = '0;
        r.instr = enc_r(funct, sh);
        r.rs    = a;
        r.rt    = b;
        case (funct)
            6'h21: r.res = a + b;
            6'h23: r.res = a + ~b + 32'd1;  // Two's complement
            6'h24: r.res = a & b;
            6'h25: r.res = a | b;
            6'h26: r.res = a ^ b;
            6'h2a: r.res = (int'(a) < int'(b)) ? 32'd1 : 32'd0;
            6'h2b: r.res = (a < b) ? 32'd1 : 32'd0;
            6'h00: r.res = b << sh;
            6'h02: r.res = b >> sh;
            6'h03: r.res = 32'(int'(b) >>> sh);
            6'h04: r.res = b << a[4:0];  // Amount from rs
            6'h06: r.res = b >> a[4:0];
            6'h07: r.res = 32'(int'(b) >>> a[4:0]);
            6'h18: p = longint'(int'(a)) * longint'(int'(b));
            6'h19: p = longint'({32'h0, a}) * longint'({32'h0, b});
            6'h1a: begin
                r.lo = 32'(longint'(int'(a)) / longint'(int'(b)));
                r.hi = 32'(longint'(int'(a)) % longint'(int'(b)));
            end
            6'h1b: begin
                r.lo = a / b;
                r.hi = a - (a / b) * b;
            end
            default: r.res = 32'h0;
        endcase
        if (funct == 6'h18 || funct == 6'h19)
            {r.hi, r.lo} = p;
        r.chk = (funct[5:2] == 4'b0110);  // Multiply and divide only
        return r;
    endfunction

    task automatic add_row(string name, logic [31:0] ins, logic [31:0] rs, logic [31:0] rt,
                           logic [31:0] res, logic br, logic il);
        tbl.push_back(row_t'{ins, rs, rt, res, br, il, 1'b0, 32'h0, 32'h0});
        tbl_name.push_back(name);
    endtask

    // Row with a zero result and a HI/LO check
    task automatic add_hl(string name, logic [31:0] ins, logic [31:0] rs, logic [31:0] rt,
                          logic il, logic [31:0] h, logic [31:0] l);
        tbl.push_back(row_t'{ins, rs, rt, 32'h0, 1'b0, il, 1'b1, h, l});
        tbl_name.push_back(name);
    endtask

    task automatic build_table();
        add_row("addiu", enc_i(6'h09, 5'd0, 16'hfffc), 32'h10, 32'h0, 32'hc, 0, 0);
        add_row("slti", enc_i(6'h0a, 5'd0, 16'hffff), 32'h5, 32'h0, 32'h0, 0, 0);
        add_row("sltiu", enc_i(6'h0b, 5'd0, 16'hffff), 32'h10000, 32'h0, 32'h1, 0, 0);
        add_row("andi", enc_i(6'h0c, 5'd0, 16'h8f0f), 32'hffffffff, 32'h0, 32'h8f0f, 0, 0);
        add_row("ori", enc_i(6'h0d, 5'd0, 16'h8000), 32'h12340000, 32'h0, 32'h12348000, 0, 0);
        add_row("xori", enc_i(6'h0e, 5'd0, 16'hffff), 32'haaaa5555, 32'h0, 32'haaaaaaaa, 0, 0);
        add_row("lui", enc_i(6'h0f, 5'd0, 16'hbeef), 32'h1234, 32'h0, 32'hbeef0000, 0, 0);
        add_row("lw", enc_i(6'h23, 5'd0, 16'hfff8), 32'h1000, 32'h0, 32'hff8, 0, 0);
        add_row("sw", enc_i(6'h2b, 5'd0, 16'h0010), 32'h2000, 32'h0, 32'h2010, 0, 0);
        add_row("beq equal", enc_i(6'h04, 5'd0, 16'h8), 32'h7, 32'h7, 32'h0, 1, 0);
        add_row("beq differ", enc_i(6'h04, 5'd0, 16'h8), 32'h7, 32'h8, 32'hffffffff, 0, 0);
        add_row("bne differ", enc_i(6'h05, 5'd0, 16'h8), 32'h7, 32'h8, 32'h1, 1, 0);
        add_row("bne equal", enc_i(6'h05, 5'd0, 16'h8), 32'h9, 32'h9, 32'h0, 0, 0);
        add_row("blez zero", enc_i(6'h06, 5'd0, 16'h8), 32'h0, 32'h5, 32'h1, 1, 0);
        add_row("blez pos", enc_i(6'h06, 5'd0, 16'h8), 32'h5, 32'h0, 32'h0, 0, 0);
        add_row("blez neg", enc_i(6'h06, 5'd0, 16'h8), 32'h80000000, 32'h0, 32'h1, 1, 0);
        add_row("bgtz pos", enc_i(6'h07, 5'd0, 16'h8), 32'h5, 32'h0, 32'h1, 1, 0);
        add_row("bgtz zero", enc_i(6'h07, 5'd0, 16'h8), 32'h0, 32'h0, 32'h0, 0, 0);
        add_row("bgtz neg", enc_i(6'h07, 5'd0, 16'h8), 32'hffffffff, 32'h0, 32'h0, 0, 0);
        add_row("bltz neg", enc_i(6'h01, 5'h00, 16'h8), 32'hffffffff, 32'h0, 32'h1, 1, 0);
        add_row("bltz zero", enc_i(6'h01, 5'h00, 16'h8), 32'h0, 32'h0, 32'h0, 0, 0);
        add_row("bgez zero", enc_i(6'h01, 5'h01, 16'h8), 32'h0, 32'h0, 32'h1, 1, 0);
        add_row("bgez neg", enc_i(6'h01, 5'h01, 16'h8), 32'h80000001, 32'h0, 32'h0, 0, 0);
        add_row("bltzal", enc_i(6'h01, 5'h10, 16'h8), 32'h80000000, 32'h0, 32'h1, 1, 0);
        add_row("bgezal", enc_i(6'h01, 5'h11, 16'h8), 32'h3, 32'h0, 32'h1, 1, 0);
        add_hl("mult", enc_r(6'h18, 5'd0), 32'hfffffffd, 32'h7, 0, 32'hffffffff, 32'hffffffeb);
        add_hl("multu", enc_r(6'h19, 5'd0), 32'hffffffff, 32'h2, 0, 32'h1, 32'hfffffffe);
        add_hl("div", enc_r(6'h1a, 5'd0), 32'hfffffff9, 32'h2, 0, 32'hffffffff, 32'hfffffffd);
        add_hl("divu", enc_r(6'h1b, 5'd0), 32'd100, 32'd7, 0, 32'h2, 32'he);
        add_hl("divu by zero", enc_r(6'h1b, 5'd0), 32'h5, 32'h0, 0, 32'h2, 32'he);
        add_hl("div by zero", enc_r(6'h1a, 5'd0), 32'h5, 32'h0, 0, 32'h2, 32'he);
        add_hl("mthi", enc_r(6'h11, 5'd0), 32'hcafef00d, 32'h0, 0, 32'hcafef00d, 32'he);
        add_row("mfhi", enc_r(6'h10, 5'd0), 32'h0, 32'h0, 32'hcafef00d, 0, 0);
        add_hl("mtlo", enc_r(6'h13, 5'd0), 32'h0badbeef, 32'h0, 0, 32'hcafef00d, 32'h0badbeef);
        add_row("mflo", enc_r(6'h12, 5'd0), 32'h0, 32'h0, 32'h0badbeef, 0, 0);
        add_row("jr", enc_r(6'h08, 5'd0), 32'h00400020, 32'h0, 32'h00400020, 0, 0);
        add_row("jalr", enc_r(6'h09, 5'd0), 32'h00400100, 32'h0, 32'h00400100, 0, 0);
        add_row("j", enc_i(6'h02, 5'd0, 16'h1234), 32'h1234, 32'h0, 32'h1234, 0, 0);
        add_hl("bad opcode", enc_i(6'h3f, 5'd0, 16'h1), 32'h5, 32'h6, 1, 32'hcafef00d, 32'h0badbeef);
        add_hl("bad funct", enc_r(6'h3f, 5'd0), 32'h5, 32'h6, 1, 32'hcafef00d, 32'h0badbeef);
        add_hl("bad regimm", enc_i(6'h01, 5'h02, 16'h8), 32'hffffffff, 32'h0, 1,
               32'hcafef00d, 32'h0badbeef);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_row(row_t r, string name);
        @(posedge clk);
        valid    <= 1'b1;
        instr    <= r.instr;
        rs_value <= r.rs;
        rt_value <= r.rt;
        exp_q.push_back(r);
        name_q.push_back(name);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        valid <= 1'b0;
        instr <= 32'hffffffff;  // Must not reach the outputs
    endtask

    // Result checker, samples between edges
    always @(negedge clk) begin
        row_t  r;
        string nm;
        int    err0;
        if (arst_n) begin
            check_value("result_valid", result_valid, prev_valid);  // One cycle behind valid
            if (result_valid && exp_q.size() == 0) begin
                $display("Error at %0t ns: result_valid with no instruction in flight", $time);
                errors++;
            end else if (result_valid) begin
                r    = exp_q.pop_front();
                nm   = name_q.pop_front();
                err0 = errors;
                check_value("result", result, r.res);
                check_value("branch_taken", branch_taken, r.br);
                check_value("illegal", illegal, r.il);
                if (r.chk) begin
                    check_value("hi", hi, r.hi);
                    check_value("lo", lo, r.lo);
                end
                held = r;
                tests_run++;
                if (errors != err0)
                    tests_failed++;
                $display("Test %0d %s: %s", tests_run, nm, (errors == err0) ? "ok" : "FAILED");
            end else begin
                check_value("result", result, held.res);  // Held while idle
                check_value("branch_taken", branch_taken, held.br);
                check_value("illegal", illegal, held.il);
            end
        end
        prev_valid = valid;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [5:0]  funct;
        logic [31:0] b;
        int          err0;
        clk      = 1'b0;
        arst_n   = 1'b0;
        valid    = 1'b0;
        instr    = 32'h0;
        rs_value = 32'h0;
        rt_value = 32'h0;
        build_table();
        cycle_limit = tbl.size() + 2 * N_RAND + 40;  // At most one idle per random row
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        err0 = errors;  // Outputs right after reset
        check_value("result", result, 32'h0);
        check_value("branch_taken", branch_taken, 32'h0);
        check_value("illegal", illegal, 32'h0);
        check_value("hi", hi, RESET_VAL);
        check_value("lo", lo, RESET_VAL);
        tests_run++;
        if (errors != err0)
            tests_failed++;
        $display("Test %0d reset state: %s", tests_run, (errors == err0) ? "ok" : "FAILED");
        foreach (tbl[i])
            drive_row(tbl[i], tbl_name[i]);  // Back to back strobes
        repeat (3) idle_cycle();
        for (int n = 0; n < N_RAND; n++) begin
            funct = RAND_FUNCT[rand_bits(5) % 17];
            b     = rand_bits(32);
            if (funct[5:1] == 5'b01101 && b == 32'h0)
                b = 32'h1;  // Keep random divides defined
            drive_row(model_rtype(funct, rand_bits(5), rand_bits(32), b),
                      $sformatf("random funct %h", funct));
            if (rand_bits(2) == 32'h0)
                idle_cycle();  // Occasional gap between strobes
        end
        idle_cycle();
        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
        $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed,
                 errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: source/mips_execute.sv
`timescale 1ns/10ps
module mips_execute #(
    parameter mips_exec_pkg::word_t RESET_HI_LO = '0
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid,
    input  mips_exec_pkg::word_t instr,
    input  mips_exec_pkg::word_t rs_value,
    input  mips_exec_pkg::word_t rt_value,
    output mips_exec_pkg::word_t result,
    output mips_exec_pkg::word_t hi,
    output mips_exec_pkg::word_t lo,
    output logic                 branch_taken,
    output logic                 illegal,
    output logic                 result_valid
);

    mips_exec_pkg::opcode_t   op;
    mips_exec_pkg::reg_idx_t  rt_field;
    mips_exec_pkg::shamt_t    shamt;
    mips_exec_pkg::funct_t    funct;
    logic [15:0]              imm;
    mips_exec_pkg::aluop_t    aluop;
    mips_exec_pkg::alu_ctrl_e alu_ctrl;
    logic                     use_imm;
    logic                     imm_zero_ext;
    logic                     is_branch;
    logic                     illegal_op;
    logic                     illegal_fn;

    assign op       = instr[31:26];
    assign rt_field = instr[20:16];  // REGIMM branch kind
    assign shamt    = instr[10:6];
    assign funct    = instr[5:0];
    assign imm      = instr[15:0];

    main_decoder u_main_dec (
        .op(op), .aluop(aluop), .use_imm(use_imm), .imm_zero_ext(imm_zero_ext),
        .is_branch(is_branch), .illegal_op(illegal_op)
    );

    alu_decoder u_alu_dec (
        .aluop(aluop), .op(op), .funct(funct), .dest(rt_field),
        .alu_ctrl(alu_ctrl), .illegal_fn(illegal_fn)
    );

    alu #(.RESET_HI_LO(RESET_HI_LO)) u_alu (
        .clk(clk), .arst_n(arst_n), .valid(valid), .alu_ctrl(alu_ctrl),
        .src_a(rs_value), .src_b(rt_value), .imm(imm), .use_imm(use_imm),
        .imm_zero_ext(imm_zero_ext), .is_branch(is_branch),
        .illegal_in(illegal_op | illegal_fn),  // Either level can reject
        .shamt(shamt), .result(result), .hi(hi), .lo(lo),
        .branch_taken(branch_taken), .illegal(illegal), .result_valid(result_valid)
    );

endmodule

// File: source/alu.sv
`timescale 1ns/10ps
module alu #(
    parameter mips_exec_pkg::word_t RESET_HI_LO = '0
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     valid,
    input  mips_exec_pkg::alu_ctrl_e alu_ctrl,
    input  mips_exec_pkg::word_t     src_a,
    input  mips_exec_pkg::word_t     src_b,
    input  logic [15:0]              imm,
    input  logic                     use_imm,
    input  logic                     imm_zero_ext,
    input  logic                     is_branch,
    input  logic                     illegal_in,
    input  mips_exec_pkg::shamt_t    shamt,
    output mips_exec_pkg::word_t     result,
    output mips_exec_pkg::word_t     hi,
    output mips_exec_pkg::word_t     lo,
    output logic                     branch_taken,
    output logic                     illegal,
    output logic                     result_valid
);

    mips_exec_pkg::word_t imm_ext;
    mips_exec_pkg::word_t op_b;
    mips_exec_pkg::word_t res_c;
    mips_exec_pkg::word_t hi_n;
    mips_exec_pkg::word_t lo_n;
    logic signed [63:0]   prod_s;
    logic [63:0]          prod_u;
    logic                 a_eq_b;
    logic                 a_zero;
    logic                 cond;

    assign imm_ext = imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign op_b    = use_imm ? imm_ext : src_b;   // rt or immediate
    assign prod_s  = $signed(src_a) * $signed(op_b);
    assign prod_u  = src_a * op_b;                // Zero extended to 64 bits
    assign a_eq_b  = (src_a == op_b);
    assign a_zero  = (src_a == '0);

    always_comb begin
        case (alu_ctrl)
            mips_exec_pkg::ALU_SUBU: cond = a_eq_b;             // BEQ
            mips_exec_pkg::ALU_BNE:  cond = !a_eq_b;
            mips_exec_pkg::ALU_BLTZ: cond = src_a[31];
            mips_exec_pkg::ALU_BGEZ: cond = !src_a[31];
            mips_exec_pkg::ALU_BGTZ: cond = !src_a[31] && !a_zero;
            mips_exec_pkg::ALU_BLEZ: cond = src_a[31] || a_zero;
            default:                 cond = 1'b0;
        endcase
    end

    always_comb begin
        res_c = '0;  // Multiply, divide and MTxx leave the result at zero
        case (alu_ctrl)
            mips_exec_pkg::ALU_AND:   res_c = src_a & op_b;
            mips_exec_pkg::ALU_OR:    res_c = src_a | op_b;
            mips_exec_pkg::ALU_XOR:   res_c = src_a ^ op_b;
            mips_exec_pkg::ALU_ADDU:  res_c = src_a + op_b;
            mips_exec_pkg::ALU_SUBU:  res_c = src_a - op_b;
            mips_exec_pkg::ALU_SLTU:  res_c = {31'b0, src_a < op_b};
            mips_exec_pkg::ALU_SLT:   res_c = {31'b0, $signed(src_a) < $signed(op_b)};
            mips_exec_pkg::ALU_SLL:   res_c = op_b << shamt;
            mips_exec_pkg::ALU_SRL:   res_c = op_b >> shamt;
            mips_exec_pkg::ALU_SRA:   res_c = $signed(op_b) >>> shamt;
            mips_exec_pkg::ALU_SLLV:  res_c = op_b << src_a[4:0];  // Amount from rs
            mips_exec_pkg::ALU_SRLV:  res_c = op_b >> src_a[4:0];
            mips_exec_pkg::ALU_SRAV:  res_c = $signed(op_b) >>> src_a[4:0];
            mips_exec_pkg::ALU_LUI:   res_c = {imm, 16'b0};
            mips_exec_pkg::ALU_MFHI:  res_c = hi;
            mips_exec_pkg::ALU_MFLO:  res_c = lo;
            mips_exec_pkg::ALU_PASSA: res_c = src_a;               // Jumps and JR/JALR
            mips_exec_pkg::ALU_BNE,
            mips_exec_pkg::ALU_BLTZ,
            mips_exec_pkg::ALU_BGEZ,
            mips_exec_pkg::ALU_BGTZ,
            mips_exec_pkg::ALU_BLEZ:  res_c = {31'b0, cond};       // Decision as a flag
            default:                  res_c = '0;
        endcase
    end

    always_comb begin
        hi_n = hi;
        lo_n = lo;
        case (alu_ctrl)
            mips_exec_pkg::ALU_MULT:  {hi_n, lo_n} = prod_s;
            mips_exec_pkg::ALU_MULTU: {hi_n, lo_n} = prod_u;
            mips_exec_pkg::ALU_DIV: if (op_b != '0) begin     // Zero divisor keeps HI/LO
                lo_n = $signed(src_a) / $signed(op_b);
                hi_n = $signed(src_a) % $signed(op_b);
            end
            mips_exec_pkg::ALU_DIVU: if (op_b != '0) begin
                lo_n = src_a / op_b;
                hi_n = src_a % op_b;
            end
            mips_exec_pkg::ALU_MTHI:  hi_n = src_a;
            mips_exec_pkg::ALU_MTLO:  lo_n = src_a;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= RESET_HI_LO;
            lo <= RESET_HI_LO;
        end else if (valid && !illegal_in) begin  // Illegal ops must not touch HI/LO
            hi <= hi_n;
            lo <= lo_n;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result       <= '0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid;                 // One cycle strobe
            if (valid) begin
                result       <= illegal_in ? '0 : res_c;
                branch_taken <= is_branch && cond && !illegal_in;
                illegal      <= illegal_in;
            end
        end
    end

    // Output strobe tracks the input strobe by exactly one cycle
    assert property (@(posedge clk) disable iff (!arst_n) result_valid |-> $past(valid));
    assert property (@(posedge clk) disable iff (!arst_n) illegal |-> result == '0);

endmodule

// File: source/alu_decoder.sv
`timescale 1ns/10ps
module alu_decoder (
    input  mips_exec_pkg::aluop_t    aluop,
    input  mips_exec_pkg::opcode_t   op,
    input  mips_exec_pkg::funct_t    funct,
    input  mips_exec_pkg::reg_idx_t  dest,
    output mips_exec_pkg::alu_ctrl_e alu_ctrl,
    output logic                     illegal_fn
);

    always_comb begin
        alu_ctrl   = mips_exec_pkg::ALU_PASSA; // Safe value for anything unlisted
        illegal_fn = 1'b0;
        case (aluop)
            mips_exec_pkg::ALUOP_MEM:  alu_ctrl = mips_exec_pkg::ALU_ADDU;  // Effective address
            mips_exec_pkg::ALUOP_JUMP: alu_ctrl = mips_exec_pkg::ALU_PASSA; // J and JAL
            mips_exec_pkg::ALUOP_DECODE: begin
                case (op)
                    mips_exec_pkg::OP_LUI:   alu_ctrl = mips_exec_pkg::ALU_LUI;
                    mips_exec_pkg::OP_BEQ:   alu_ctrl = mips_exec_pkg::ALU_SUBU; // Equal test
                    mips_exec_pkg::OP_BLEZ:  alu_ctrl = mips_exec_pkg::ALU_BLEZ;
                    mips_exec_pkg::OP_BGTZ:  alu_ctrl = mips_exec_pkg::ALU_BGTZ;
                    mips_exec_pkg::OP_BNE:   alu_ctrl = mips_exec_pkg::ALU_BNE;
                    mips_exec_pkg::OP_ADDIU: alu_ctrl = mips_exec_pkg::ALU_ADDU;
                    mips_exec_pkg::OP_ANDI:  alu_ctrl = mips_exec_pkg::ALU_AND;
                    mips_exec_pkg::OP_ORI:   alu_ctrl = mips_exec_pkg::ALU_OR;
                    mips_exec_pkg::OP_XORI:  alu_ctrl = mips_exec_pkg::ALU_XOR;
                    mips_exec_pkg::OP_SLTI:  alu_ctrl = mips_exec_pkg::ALU_SLT;
                    mips_exec_pkg::OP_SLTIU: alu_ctrl = mips_exec_pkg::ALU_SLTU;
                    mips_exec_pkg::OP_REGIMM: begin
                        case (dest)  // rt field holds the branch kind
                            mips_exec_pkg::RT_BGEZ,
                            mips_exec_pkg::RT_BGEZAL: alu_ctrl = mips_exec_pkg::ALU_BGEZ;
                            mips_exec_pkg::RT_BLTZ,
                            mips_exec_pkg::RT_BLTZAL: alu_ctrl = mips_exec_pkg::ALU_BLTZ;
                            default: illegal_fn = 1'b1;
                        endcase
                    end
                    mips_exec_pkg::OP_RTYPE: begin
                        case (funct)
                            6'h21: alu_ctrl = mips_exec_pkg::ALU_ADDU;
                            6'h23: alu_ctrl = mips_exec_pkg::ALU_SUBU;
                            6'h24: alu_ctrl = mips_exec_pkg::ALU_AND;
                            6'h25: alu_ctrl = mips_exec_pkg::ALU_OR;
                            6'h26: alu_ctrl = mips_exec_pkg::ALU_XOR;
                            6'h2a: alu_ctrl = mips_exec_pkg::ALU_SLT;
                            6'h2b: alu_ctrl = mips_exec_pkg::ALU_SLTU;
                            6'h19: alu_ctrl = mips_exec_pkg::ALU_MULTU;
                            6'h18: alu_ctrl = mips_exec_pkg::ALU_MULT;
                            6'h00: alu_ctrl = mips_exec_pkg::ALU_SLL;   // Also the NOP encoding
                            6'h04: alu_ctrl = mips_exec_pkg::ALU_SLLV;
                            6'h03: alu_ctrl = mips_exec_pkg::ALU_SRA;
                            6'h02: alu_ctrl = mips_exec_pkg::ALU_SRL;
                            6'h07: alu_ctrl = mips_exec_pkg::ALU_SRAV;
                            6'h06: alu_ctrl = mips_exec_pkg::ALU_SRLV;
                            6'h1a: alu_ctrl = mips_exec_pkg::ALU_DIV;
                            6'h1b: alu_ctrl = mips_exec_pkg::ALU_DIVU;
                            6'h11: alu_ctrl = mips_exec_pkg::ALU_MTHI;
                            6'h13: alu_ctrl = mips_exec_pkg::ALU_MTLO;
                            6'h10: alu_ctrl = mips_exec_pkg::ALU_MFHI;
                            6'h12: alu_ctrl = mips_exec_pkg::ALU_MFLO;
                            6'h08,
                            6'h09: alu_ctrl = mips_exec_pkg::ALU_PASSA; // JR and JALR give rs
                            default: illegal_fn = 1'b1;
                        endcase
                    end
                    default: illegal_fn = 1'b1;  // Opcode with no second level entry
                endcase
            end
            default: illegal_fn = 1'b1;
        endcase
    end

    // Main decoder only produces three classes
    assert final (aluop != 2'b11);

endmodule

// File: source/main_decoder.sv
`timescale 1ns/10ps
module main_decoder (
    input  mips_exec_pkg::opcode_t op,
    output mips_exec_pkg::aluop_t  aluop,
    output logic                   use_imm,
    output logic                   imm_zero_ext,
    output logic                   is_branch,
    output logic                   illegal_op
);

    always_comb begin
        aluop        = mips_exec_pkg::ALUOP_DECODE; // Second level decode by default
        use_imm      = 1'b0;
        imm_zero_ext = 1'b0;
        is_branch    = 1'b0;
        illegal_op   = 1'b0;
        case (op)
            mips_exec_pkg::OP_RTYPE: begin
                aluop = mips_exec_pkg::ALUOP_DECODE;  // Funct picks the op
            end
            mips_exec_pkg::OP_REGIMM,
            mips_exec_pkg::OP_BEQ,
            mips_exec_pkg::OP_BNE,
            mips_exec_pkg::OP_BLEZ,
            mips_exec_pkg::OP_BGTZ: begin
                is_branch = 1'b1;                     // Compare rs against rt or zero
            end
            mips_exec_pkg::OP_J,
            mips_exec_pkg::OP_JAL: begin
                aluop = mips_exec_pkg::ALUOP_JUMP;    // Target comes from outside
            end
            mips_exec_pkg::OP_ADDIU,
            mips_exec_pkg::OP_SLTI,
            mips_exec_pkg::OP_SLTIU: begin
                use_imm = 1'b1;                       // Sign extended immediate
            end
            mips_exec_pkg::OP_ANDI,
            mips_exec_pkg::OP_ORI,
            mips_exec_pkg::OP_XORI,
            mips_exec_pkg::OP_LUI: begin
                use_imm      = 1'b1;
                imm_zero_ext = 1'b1;                  // Logical ops take zero extension
            end
            mips_exec_pkg::OP_LB,
            mips_exec_pkg::OP_LH,
            mips_exec_pkg::OP_LW,
            mips_exec_pkg::OP_LBU,
            mips_exec_pkg::OP_LHU,
            mips_exec_pkg::OP_SB,
            mips_exec_pkg::OP_SH,
            mips_exec_pkg::OP_SW: begin
                aluop   = mips_exec_pkg::ALUOP_MEM;   // rs plus offset
                use_imm = 1'b1;
            end
            default: begin
                illegal_op = 1'b1;                    // Unsupported opcode
            end
        endcase
    end

    // Branches compare against rt, never against the immediate
    assert final (!(is_branch && use_imm));

endmodule

// File: source/mips_exec_pkg.sv
package mips_exec_pkg;

    typedef logic [31:0] word_t;    // Data word
    typedef logic [5:0]  opcode_t;  // instr[31:26]
    typedef logic [5:0]  funct_t;   // instr[5:0]
    typedef logic [4:0]  reg_idx_t; // Register index or REGIMM rt code
    typedef logic [4:0]  shamt_t;   // instr[10:6]
    typedef logic [1:0]  aluop_t;   // First level decode class

    localparam aluop_t ALUOP_MEM    = 2'b00; // Address add
    localparam aluop_t ALUOP_JUMP   = 2'b01; // Pass A through
    localparam aluop_t ALUOP_DECODE = 2'b10; // Look at opcode and funct

    typedef enum logic [4:0] {
        ALU_AND   = 5'b00000,
        ALU_OR    = 5'b00001,
        ALU_XOR   = 5'b00010,
        ALU_ADDU  = 5'b00011,
        ALU_SUBU  = 5'b00100, // Also BEQ with the branch flag
        ALU_SLTU  = 5'b00101,
        ALU_SLT   = 5'b00110,
        ALU_MULTU = 5'b00111,
        ALU_MULT  = 5'b01000,
        ALU_SLL   = 5'b01001,
        ALU_SLLV  = 5'b01010,
        ALU_SRA   = 5'b01011,
        ALU_SRL   = 5'b01100,
        ALU_SRAV  = 5'b01101,
        ALU_SRLV  = 5'b01110,
        ALU_DIV   = 5'b01111,
        ALU_DIVU  = 5'b10000,
        ALU_MTHI  = 5'b10001,
        ALU_MTLO  = 5'b10010,
        ALU_BLTZ  = 5'b10011,
        ALU_BGTZ  = 5'b10100,
        ALU_BGEZ  = 5'b10101,
        ALU_BNE   = 5'b10110,
        ALU_BLEZ  = 5'b10111,
        ALU_PASSA = 5'b11000,
        ALU_LUI   = 5'b11001,
        ALU_MFHI  = 5'b11010,
        ALU_MFLO  = 5'b11011
    } alu_ctrl_e;

    // Primary opcodes
    localparam opcode_t OP_RTYPE  = 6'h00;
    localparam opcode_t OP_REGIMM = 6'h01;
    localparam opcode_t OP_J      = 6'h02;
    localparam opcode_t OP_JAL    = 6'h03;
    localparam opcode_t OP_BEQ    = 6'h04;
    localparam opcode_t OP_BNE    = 6'h05;
    localparam opcode_t OP_BLEZ   = 6'h06;
    localparam opcode_t OP_BGTZ   = 6'h07;
    localparam opcode_t OP_ADDIU  = 6'h09;
    localparam opcode_t OP_SLTI   = 6'h0a;
    localparam opcode_t OP_SLTIU  = 6'h0b;
    localparam opcode_t OP_ANDI   = 6'h0c;
    localparam opcode_t OP_ORI    = 6'h0d;
    localparam opcode_t OP_XORI   = 6'h0e;
    localparam opcode_t OP_LUI    = 6'h0f;
    localparam opcode_t OP_LB     = 6'h20;
    localparam opcode_t OP_LH     = 6'h21;
    localparam opcode_t OP_LW     = 6'h23;
    localparam opcode_t OP_LBU    = 6'h24;
    localparam opcode_t OP_LHU    = 6'h25;
    localparam opcode_t OP_SB     = 6'h28;
    localparam opcode_t OP_SH     = 6'h29;
    localparam opcode_t OP_SW     = 6'h2b;

    // REGIMM rt field codes
    localparam reg_idx_t RT_BLTZ   = 5'b00000;
    localparam reg_idx_t RT_BGEZ   = 5'b00001;
    localparam reg_idx_t RT_BLTZAL = 5'b10000;
    localparam reg_idx_t RT_BGEZAL = 5'b10001;

endpackage
